//--- all.f
+incdir+.
fpPkg.sv
fpMulTrunc.sv
fpSubTrunc.sv
fpRsqrte.sv
rsqrtUnit.sv
tbClock.sv
rsqrtTb.sv

//--- rsqrtTb.sv
// ========================================
// testbench for the rsqrt estimator, runs req/ack requests and
// checks each estimate against a truncating reference model
// ========================================
`timescale 1ns/1ps
`default_nettype none
`include "fpConsts.svh"

module rsqrtTb;

	localparam int ackLatency = 13;
	localparam int numDirected = 7;
	localparam int numRandom = 200;
	localparam int numBackToBack = 10;
	localparam int numTests = numDirected + numRandom + numBackToBack;
	// one request is the latency, up to 10 hold cycles, a gap and the ack fall
	localparam int cyclesPerTest = ackLatency + 10 + 2 + 5;
	localparam int cycleLimit = cyclesPerTest * numTests + 50;

	logic clk;
	logic arstN;
	logic req;
	fpPkg::floatT operand;
	logic ack;
	fpPkg::floatT estimate;

	integer seed;
	int unsigned cycleCnt;
	int reqCnt;
	int resultCnt;
	int checkCnt;
	int errCnt;
	// the accuracy rule only holds where no intermediate value flushes
	logic checkRange;

	// monitor view of the previous edge and of the request in flight
	logic busy;
	logic ackPrev;
	logic reqPrev;
	fpPkg::floatT estPrev;
	fpPkg::floatT capOperand;
	fpPkg::floatT expEst;
	int unsigned capCycle;
	int latency;
	real estReal;
	real trueReal;
	real relErr;

	tbClock #(.halfPeriod(50), .resetCycles(5)) clkGen (.clk(clk), .arstN(arstN));

	rsqrtUnit DUT (
		.clk(clk),
		.arstN(arstN),
		.req(req),
		.operand(operand),
		.ack(ack),
		.estimate(estimate)
	);

	// ========================================
	// reference model
	// ========================================
	// product with the low significand bits cut off, flush below and saturate above
	function automatic fpPkg::floatT truncMul(input fpPkg::floatT a, input fpPkg::floatT b);
		logic sign;
		int e;
		logic [47:0] sigA;
		logic [47:0] sigB;
		logic [47:0] prod;
		logic [22:0] frac;
		sign = a[31] ^ b[31];
		if ((a[30:23] == 8'd0) || (b[30:23] == 8'd0))
			return {sign, 31'd0};
		sigA = {24'd0, 1'b1, a[22:0]};
		sigB = {24'd0, 1'b1, b[22:0]};
		prod = sigA * sigB;
		e = int'(a[30:23]) + int'(b[30:23]) - 127;
		// two significands in [1,2) give a product in [1,4)
		if (prod[47])
		begin
			e = e + 1;
			frac = prod[46:24];
		end
		else
			frac = prod[45:23];
		if (e < 1)
			return {sign, 31'd0};
		if (e > 254)
			return {sign, 8'hfe, 23'h7f_ffff};
		return {sign, e[7:0], frac};
	endfunction

	// a - b with the smaller operand aligned by dropping bits
	function automatic fpPkg::floatT truncSub(input fpPkg::floatT a, input fpPkg::floatT b);
		fpPkg::floatT hi;
		fpPkg::floatT lo;
		logic sign;
		logic addMags;
		int eHi;
		int eLo;
		int lz;
		logic [24:0] sigHi;
		logic [24:0] sigLo;
		logic [24:0] mag;
		if (b[30:0] > a[30:0])
		begin
			hi = b;
			lo = a;
			sign = ~b[31];
		end
		else
		begin
			hi = a;
			lo = b;
			sign = a[31];
		end
		// different signs turn the subtraction into a sum of magnitudes
		addMags = a[31] != b[31];
		eHi = int'(hi[30:23]);
		eLo = int'(lo[30:23]);
		sigHi = (eHi == 0) ? 25'd0 : {2'b01, hi[22:0]};
		sigLo = (eLo == 0) ? 25'd0 : {2'b01, lo[22:0]};
		sigLo = sigLo >> (eHi - eLo);
		mag = addMags ? (sigHi + sigLo) : (sigHi - sigLo);
		if (mag[24])
		begin
			if (eHi + 1 > 254)
				return {sign, 8'hfe, 23'h7f_ffff};
			eHi = eHi + 1;
			return {sign, eHi[7:0], mag[23:1]};
		end
		if (mag == 25'd0)
			return 32'h0;
		lz = 0;
		while (!mag[23])
		begin
			mag = mag << 1;
			lz++;
		end
		if (eHi <= lz)
			return {sign, 31'd0};
		eHi = eHi - lz;
		return {sign, eHi[7:0], mag[22:0]};
	endfunction

	// magic guess, then y * (1.5 - (0.5 * x) * y * y) in that order
	function automatic fpPkg::floatT rsqrtModel(input fpPkg::floatT x);
		fpPkg::floatT y;
		fpPkg::floatT halfX;
		fpPkg::floatT ySq;
		fpPkg::floatT prod;
		fpPkg::floatT corr;
		// halving and negating the exponent happen in one integer subtraction
		y = `FP_RSQ_MAGIC - (x >> 1);
		halfX = truncMul(x, `FP_POINT5);
		ySq = truncMul(y, y);
		prod = truncMul(halfX, ySq);
		corr = truncSub(`FP_ONEPOINT5, prod);
		return truncMul(y, corr);
	endfunction

	// widen a normal single float into a double for the accuracy check
	function automatic real floatToReal(input fpPkg::floatT f);
		logic [10:0] expD;
		if (f[30:23] == 8'd0)
			return 0.0;
		expD = {3'b000, f[30:23]} + 11'd896;
		return $bitstoreal({f[31], expD, f[22:0], 29'd0});
	endfunction

	function automatic fpPkg::floatT directedOperand(input int idx);
		case (idx)
			0: return 32'h3f80_0000;
			1: return 32'h4080_0000;
			2: return 32'h3e80_0000;
			3: return 32'h4000_0000;
			4: return 32'h42c8_0000;
			// largest and smallest normal values
			5: return 32'h7f7f_ffff;
			default: return 32'h0080_0000;
		endcase
	endfunction

	task automatic pickOperand(output fpPkg::floatT op);
		logic [31:0] r;
		int e;
		r = $random(seed);
		// exponents 2 to 251 keep x/2 and y*y clear of underflow
		e = 2 + int'($unsigned($random(seed)) % 250);
		op = {1'b0, e[7:0], r[22:0]};
	endtask

	// ========================================
	// one four-phase request
	// ========================================
	task automatic runRequest(input fpPkg::floatT op, input int hold, input int gap);
		if (gap > 0)
		begin
			repeat (gap) @(posedge clk);
			#1;
		end
		req = 1'b1;
		operand = op;
		reqCnt++;
		// the cycle counter bounds every wait below
		@(posedge clk);
		#1;
		while (ack !== 1'b1)
		begin
			@(posedge clk);
			#1;
		end
		// back-pressure, the client sits on the answer for a while
		repeat (hold)
		begin
			@(posedge clk);
			#1;
		end
		req = 1'b0;
		@(posedge clk);
		#1;
		while (ack !== 1'b0)
		begin
			@(posedge clk);
			#1;
		end
	endtask

	// ========================================
	// compare process
	// ========================================
	// sampled at the rising edge, so every value is the one the DUT sees there
	always @(posedge clk)
	begin
		if (!arstN)
		begin
			busy = 1'b0;
			ackPrev = 1'b0;
			reqPrev = 1'b0;
			estPrev = 32'h0;
		end
		else
		begin
			// ack dropped on the previous edge, req must have been low there
			if (ackPrev && !ack)
			begin
				checkCnt++;
				if (reqPrev)
				begin
					errCnt++;
					$display("ack fell while req was still high");
				end
				busy = 1'b0;
			end
			// req seen low with ack high drops ack on that same edge
			if (ackPrev && !reqPrev && ack)
			begin
				errCnt++;
				$display("ack stayed high after req went low");
			end
			if (ackPrev && ack)
			begin
				checkCnt++;
				if (estimate !== estPrev)
				begin
					errCnt++;
					$display("[ERROR] estimate: expected %h, got %h while ack held", estPrev,
						estimate);
				end
			end
			// the DUT takes the operand on this edge
			if (!busy && req && !ack)
			begin
				busy = 1'b1;
				capCycle = cycleCnt;
				capOperand = operand;
				expEst = rsqrtModel(operand);
			end
			// ack went high on the previous edge
			if (!ackPrev && ack)
			begin
				checkCnt++;
				resultCnt++;
				latency = int'(cycleCnt) - 1 - int'(capCycle);
				if (!busy)
				begin
					errCnt++;
					$display("ack rose with no request in progress");
				end
				else
				begin
					if (!reqPrev)
					begin
						errCnt++;
						$display("ack rose while req was low");
					end
					if (latency != ackLatency)
					begin
						errCnt++;
						$display("ack rose %0d cycles after capture instead of %0d", latency,
							ackLatency);
					end
					if (estimate !== expEst)
					begin
						errCnt++;
						$display("[ERROR] estimate: expected %h, got %h for operand %h", expEst,
							estimate, capOperand);
					end
					// accuracy against the true value, independent of the model
					if (checkRange)
					begin
						estReal = floatToReal(estimate);
						trueReal = 1.0 / $sqrt(floatToReal(capOperand));
						relErr = (estReal - trueReal) / trueReal;
						if (relErr < 0.0)
							relErr = -relErr;
						if (relErr > 0.002)
						begin
							errCnt++;
							$display("[ERROR] estimate: %h is off by %f percent for operand %h",
								estimate, relErr * 100.0, capOperand);
						end
					end
				end
			end
			ackPrev = ack;
			reqPrev = req;
			estPrev = estimate;
		end
	end

	// ========================================
	// timeout
	// ========================================
	always @(posedge clk)
	begin
		cycleCnt <= cycleCnt + 1;
		if (cycleCnt >= cycleLimit)
		begin
			$display("timeout: the run did not finish within %0d cycles", cycleLimit);
			$display("requests %0d, results %0d, checks %0d, errors %0d", reqCnt, resultCnt,
				checkCnt, errCnt);
			$display("tests failed");
			$finish;
		end
	end

	// ========================================
	// stimulus
	// ========================================
	initial
	begin : stimulus
		fpPkg::floatT op;
		int hold;
		seed = 32'h584f_649f;
		req = 1'b0;
		operand = 32'h0;
		checkRange = 1'b0;
		cycleCnt = 0;
		reqCnt = 0;
		resultCnt = 0;
		checkCnt = 0;
		errCnt = 0;
		wait (arstN === 1'b1);
		@(posedge clk);
		#1;
		// outputs straight after reset, before any request
		checkCnt++;
		if (ack !== 1'b0)
		begin
			errCnt++;
			$display("[ERROR] ack: expected %h, got %h after reset", 1'b0, ack);
		end
		if (estimate !== 32'h0)
		begin
			errCnt++;
			$display("[ERROR] estimate: expected %h, got %h after reset", 32'h0, estimate);
		end
		for (int i = 0; i < numDirected; i++)
			runRequest(directedOperand(i), 0, 2);
		checkRange = 1'b1;
		for (int i = 0; i < numRandom; i++)
		begin
			pickOperand(op);
			hold = int'($unsigned($random(seed)) % 11);
			runRequest(op, hold, 1);
		end
		// a new req right on the edge where ack fell
		for (int i = 0; i < numBackToBack; i++)
		begin
			pickOperand(op);
			runRequest(op, 0, 0);
		end
		repeat (3)
		begin
			@(posedge clk);
			#1;
		end
		if (resultCnt != reqCnt)
		begin
			errCnt++;
			$display("only %0d of %0d requests returned a result", resultCnt, reqCnt);
		end
		$display("requests %0d, results %0d, checks %0d, errors %0d", reqCnt, resultCnt,
			checkCnt, errCnt);
		if (errCnt == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- tbClock.sv
// ========================================
// testbench clock and active-low reset, instanced once by the top
// ========================================
`timescale 1ns/1ps
`default_nettype none

module tbClock #(
	parameter int halfPeriod = 50,
	parameter int resetCycles = 5
) (
	output logic clk,
	output logic arstN
);

	// free-running clock, first rising edge half a period in
	initial
	begin
		clk = 1'b0;
		forever
			#halfPeriod clk = ~clk;
	end

	// reset leaves a little after an edge, like any other input
	initial
	begin
		arstN = 1'b0;
		repeat (resetCycles) @(posedge clk);
		#1;
		arstN = 1'b1;
	end

endmodule

`default_nettype wire

//--- rsqrtUnit.sv
// ======================================
// rsqrt estimator top, sequencer with its two multipliers and subtractor
// ======================================
`timescale 1ns/1ps
`default_nettype none

module rsqrtUnit (
	input  logic         clk,
	input  logic         arstN,
	input  logic         req,
	input  fpPkg::floatT operand,
	output logic         ack,
	output fpPkg::floatT estimate
);

	// operand pairs from the sequencer into the units
	fpPkg::fpOperandsT mulOpsA;
	fpPkg::fpOperandsT mulOpsB;
	fpPkg::fpOperandsT subOps;

	// unit results back to the sequencer
	fpPkg::floatT mulResA;
	fpPkg::floatT mulResB;
	fpPkg::floatT subRes;

	fpRsqrte seq (
		.clk(clk),
		.arstN(arstN),
		.req(req),
		.operand(operand),
		.ack(ack),
		.estimate(estimate),
		.mulOpsA(mulOpsA),
		.mulOpsB(mulOpsB),
		.subOps(subOps),
		.mulResA(mulResA),
		.mulResB(mulResB),
		.subRes(subRes)
	);

	// multiplier A runs the chained products, B only squares the guess
	fpMulTrunc mulA (.clk(clk), .arstN(arstN), .ops(mulOpsA), .res(mulResA));
	fpMulTrunc mulB (.clk(clk), .arstN(arstN), .ops(mulOpsB), .res(mulResB));

	fpSubTrunc sub0 (.clk(clk), .arstN(arstN), .ops(subOps), .res(subRes));

endmodule

`default_nettype wire

//--- fpRsqrte.sv
// ======================================
// rsqrt sequencer, magic-constant guess plus one Newton step
// takes a req/ack request and steps the shared units through the math
// ======================================
`timescale 1ns/1ps
`default_nettype none
`include "fpConsts.svh"

module fpRsqrte (
	input  logic              clk,
	input  logic              arstN,
	input  logic              req,
	input  fpPkg::floatT      operand,
	output logic              ack,
	output fpPkg::floatT      estimate,
	output fpPkg::fpOperandsT mulOpsA,
	output fpPkg::fpOperandsT mulOpsB,
	output fpPkg::fpOperandsT subOps,
	input  fpPkg::floatT      mulResA,
	input  fpPkg::floatT      mulResB,
	input  fpPkg::floatT      subRes
);

	fpPkg::rsqrtStateT state;
	// cycles left in the current step
	logic [2:0] cnt;
	fpPkg::floatT x;
	fpPkg::floatT y;
	fpPkg::floatT yGuess;
	logic capture;

	// first guess from the integer view of the float
	assign yGuess = `FP_RSQ_MAGIC - {1'b0, operand[`FP_WID-1:1]};
	assign capture = (state == fpPkg::idle) && req && !ack;

	// operand and guess stay put for the whole request
	always_ff @(posedge clk)
	begin
		if (capture)
		begin
			x <= operand;
			y <= yGuess;
		end
	end

	// ======================================
	// step sequencing and handshake
	// ======================================
	// each step lasts one unit latency, its result is then fed straight into the next step
	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			state <= fpPkg::idle;
			cnt <= 3'd0;
			ack <= 1'b0;
			estimate <= '0;
		end
		else
		begin
			case (state)
				fpPkg::idle:
				begin
					if (capture)
					begin
						state <= fpPkg::mulHalfSq;
						cnt <= 3'(`FP_MUL_LAT - 1);
					end
				end
				fpPkg::mulHalfSq:
				begin
					cnt <= cnt - 3'd1;
					if (cnt == 3'd0)
					begin
						state <= fpPkg::mulCross;
						cnt <= 3'(`FP_MUL_LAT - 1);
					end
				end
				fpPkg::mulCross:
				begin
					cnt <= cnt - 3'd1;
					if (cnt == 3'd0)
					begin
						state <= fpPkg::sub;
						cnt <= 3'(`FP_SUB_LAT - 1);
					end
				end
				fpPkg::sub:
				begin
					cnt <= cnt - 3'd1;
					if (cnt == 3'd0)
					begin
						state <= fpPkg::mulFinal;
						// one extra cycle so the product can be registered here
						cnt <= 3'(`FP_MUL_LAT);
					end
				end
				fpPkg::mulFinal:
				begin
					cnt <= cnt - 3'd1;
					if (cnt == 3'd0)
					begin
						estimate <= mulResA;
						state <= fpPkg::done;
					end
				end
				fpPkg::done:
				begin
					// raise ack once, then hold it until the client lets go of req
					if (!ack)
						ack <= 1'b1;
					else if (!req)
					begin
						ack <= 1'b0;
						state <= fpPkg::idle;
					end
				end
				default:
					state <= fpPkg::idle;
			endcase
		end
	end

	// ======================================
	// operand routing to the shared units
	// ======================================
	always_comb
	begin
		mulOpsA = '0;
		mulOpsB = '0;
		subOps = '0;
		case (state)
			fpPkg::mulHalfSq:
			begin
				mulOpsA.a = x;
				mulOpsA.b = `FP_POINT5;
				mulOpsB.a = y;
				mulOpsB.b = y;
			end
			// x2 and yy are only valid on the first cycle of this step, which is the one sampled
			fpPkg::mulCross:
			begin
				mulOpsA.a = mulResA;
				mulOpsA.b = mulResB;
			end
			fpPkg::sub:
			begin
				subOps.a = `FP_ONEPOINT5;
				subOps.b = mulResA;
			end
			fpPkg::mulFinal:
			begin
				mulOpsA.a = y;
				mulOpsA.b = subRes;
			end
			default:
			begin
				mulOpsA = '0;
			end
		endcase
	end

	// ack only rises while the client is requesting
	ackNeedsReq: assert property (@(posedge clk) disable iff (!arstN)
		$rose(ack) |-> $past(req));

	// the client keeps req up for as long as the request runs unanswered
	reqHeld: assert property (@(posedge clk) disable iff (!arstN)
		((state != fpPkg::idle) && !ack) |-> req);

	// the answer holds still while it is being offered
	estimateHeld: assert property (@(posedge clk) disable iff (!arstN)
		(ack && $past(ack)) |-> $stable(estimate));

endmodule

`default_nettype wire

//--- fpSubTrunc.sv
// ======================================
// pipelined single float subtractor computing a - b with truncation
// result appears FP_SUB_LAT edges after the operands are sampled
// ======================================
`timescale 1ns/1ps
`default_nettype none
`include "fpConsts.svh"

module fpSubTrunc (
	input  logic              clk,
	input  logic              arstN,
	input  fpPkg::fpOperandsT ops,
	output fpPkg::floatT      res
);

	logic swap;
	fpPkg::floatT big;
	fpPkg::floatT smallOp;
	fpPkg::expT bigExp;
	fpPkg::expT smallExp;
	fpPkg::expT expDiff;
	fpPkg::sigT bigSig;
	fpPkg::sigT smallSig;

	// stage 1 holds the aligned operands
	logic s1Sign;
	logic s1EffSub;
	fpPkg::expT s1Exp;
	fpPkg::sigT s1BigSig;
	fpPkg::sigT s1SmallSig;

	logic [24:0] magRaw;
	fpPkg::sigT magShift;
	logic [4:0] lz;
	fpPkg::floatT resNext;
	logic [`FP_SUB_LAT-1:0] fill;

	// counts the leading zeros of a significand and gives 24 when it is all zero
	function automatic logic [4:0] countLz(input fpPkg::sigT v);
		logic [4:0] n;
		logic seen;
		n = 5'd0;
		seen = 1'b0;
		for (int i = 23; i >= 0; i--)
		begin
			if (v[i])
				seen = 1'b1;
			else if (!seen)
				n = n + 5'd1;
		end
		return n;
	endfunction

	// ======================================
	// swap and align
	// ======================================
	// comparing the magnitude bits as one integer orders the floats by size
	assign swap = ops.b[30:0] > ops.a[30:0];
	assign big = swap ? ops.b : ops.a;
	assign smallOp = swap ? ops.a : ops.b;
	assign bigExp = big[30:23];
	assign smallExp = smallOp[30:23];
	assign expDiff = bigExp - smallExp;
	// a zero exponent field counts as zero so denormal inputs flush
	assign bigSig = (bigExp != 8'd0) ? {1'b1, big[22:0]} : 24'd0;
	assign smallSig = (smallExp != 8'd0) ? {1'b1, smallOp[22:0]} : 24'd0;

	always_ff @(posedge clk)
	begin
		s1Sign <= big[`FP_WID-1] ^ swap;
		// equal signs subtract magnitudes, different signs add them
		s1EffSub <= ops.a[`FP_WID-1] == ops.b[`FP_WID-1];
		s1Exp <= bigExp;
		s1BigSig <= bigSig;
		// bits shifted out past the significand are simply dropped
		s1SmallSig <= smallSig >> expDiff;
	end

	// ======================================
	// combine, normalize and truncate
	// ======================================
	assign magRaw = s1EffSub ? ({1'b0, s1BigSig} - {1'b0, s1SmallSig})
		: ({1'b0, s1BigSig} + {1'b0, s1SmallSig});
	assign lz = countLz(magRaw[23:0]);
	assign magShift = magRaw[23:0] << lz;

	always_comb
	begin
		if (magRaw[24])
		begin
			// carry out of an addition moves the point right by one
			if (({1'b0, s1Exp} + 9'd1) > 9'd254)
				resNext = {s1Sign, 8'hfe, 23'h7f_ffff};
			else
				resNext = {s1Sign, s1Exp + 8'd1, magRaw[23:1]};
		end
		else if (magRaw[23:0] == 24'd0)
			resNext = '0;
		else if (s1Exp <= {3'b000, lz})
			resNext = {s1Sign, 31'd0};
		else
			resNext = {s1Sign, s1Exp - {3'b000, lz}, magShift[22:0]};
	end

	always_ff @(posedge clk)
	begin
		res <= resNext;
	end

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
			fill <= '0;
		else
			fill <= {fill[`FP_SUB_LAT-2:0], 1'b1};
	end

	// once the pipeline has filled from reset the result is always known
	resKnown: assert property (@(posedge clk) disable iff (!arstN)
		fill[`FP_SUB_LAT-1] |-> !$isunknown(res));

endmodule

`default_nettype wire

//--- fpMulTrunc.sv
// ======================================
// pipelined single float multiplier, truncating
// result of ops appears FP_MUL_LAT edges after they are sampled
// ======================================
`timescale 1ns/1ps
`default_nettype none
`include "fpConsts.svh"

module fpMulTrunc (
	input  logic              clk,
	input  logic              arstN,
	input  fpPkg::fpOperandsT ops,
	output fpPkg::floatT      res
);

	fpPkg::expT expA;
	fpPkg::expT expB;

	// stage 1 holds the unpacked fields
	logic s1Sign;
	logic s1Zero;
	logic [8:0] s1ExpSum;
	fpPkg::sigT s1SigA;
	fpPkg::sigT s1SigB;

	// stage 2 holds the full significand product
	logic s2Sign;
	logic s2Zero;
	logic [8:0] s2ExpSum;
	logic [47:0] s2Prod;

	logic [9:0] expAdj;
	logic [22:0] mant;
	fpPkg::floatT resNext;

	// marks how far valid data has reached after reset
	logic [`FP_MUL_LAT-1:0] fill;

	assign expA = ops.a[30:23];
	assign expB = ops.b[30:23];

	always_ff @(posedge clk)
	begin
		s1Sign <= ops.a[`FP_WID-1] ^ ops.b[`FP_WID-1];
		// a zero exponent field means zero, denormal inputs included
		s1Zero <= (expA == 8'd0) || (expB == 8'd0);
		s1ExpSum <= {1'b0, expA} + {1'b0, expB};
		s1SigA <= {1'b1, ops.a[22:0]};
		s1SigB <= {1'b1, ops.b[22:0]};
	end

	always_ff @(posedge clk)
	begin
		s2Sign <= s1Sign;
		s2Zero <= s1Zero;
		s2ExpSum <= s1ExpSum;
		s2Prod <= s1SigA * s1SigB;
	end

	// ======================================
	// normalize by at most one place and truncate
	// ======================================
	// top product bit set means the product is in [2,4) and the exponent grows by one
	assign expAdj = {1'b0, s2ExpSum} + {9'd0, s2Prod[47]} - {2'b00, `FP_EXP_BIAS};
	assign mant = s2Prod[47] ? s2Prod[46:24] : s2Prod[45:23];

	always_comb
	begin
		// bit 9 set is a negative exponent, so underflow flushes to signed zero
		if (s2Zero || expAdj[9] || (expAdj == 10'd0))
			resNext = {s2Sign, 31'd0};
		else if (expAdj > 10'd254)
			resNext = {s2Sign, 8'hfe, 23'h7f_ffff};
		else
			resNext = {s2Sign, expAdj[7:0], mant};
	end

	always_ff @(posedge clk)
	begin
		res <= resNext;
	end

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
			fill <= '0;
		else
			fill <= {fill[`FP_MUL_LAT-2:0], 1'b1};
	end

	// once the pipeline has filled from reset the result is always known
	resKnown: assert property (@(posedge clk) disable iff (!arstN)
		fill[`FP_MUL_LAT-1] |-> !$isunknown(res));

endmodule

`default_nettype wire

//--- fpPkg.sv
// ======================================
// float field types, operand pair and sequencer states
// ======================================
`default_nettype none
`include "fpConsts.svh"

package fpPkg;

	// one IEEE single float, sign in the top bit
	typedef logic [`FP_WID-1:0] floatT;

	// biased exponent field
	typedef logic [7:0] expT;

	// significand with the hidden one made explicit
	typedef logic [23:0] sigT;

	// one operand pair for a two-input arithmetic unit
	typedef struct packed {
		floatT a;
		floatT b;
	} fpOperandsT;

	// sequencer steps of the single Newton iteration
	typedef enum logic [2:0] {
		idle,
		mulHalfSq,
		mulCross,
		sub,
		mulFinal,
		done
	} rsqrtStateT;

endpackage

`default_nettype wire

//--- fpConsts.svh
// ======================================
// shared widths, unit latencies and float constants
// for the rsqrt estimator, included by package, units and sequencer
// ======================================
`ifndef FP_CONSTS_SVH
`define FP_CONSTS_SVH

// width of an IEEE single float
`define FP_WID 32

// exponent bias of the single format
`define FP_EXP_BIAS 8'd127

// pipeline depth of the multiplier and of the subtractor
`define FP_MUL_LAT 3
`define FP_SUB_LAT 2

// magic constant of the fast inverse square root guess
`define FP_RSQ_MAGIC 32'h5f3759df

// 0.5 and 1.5 as single floats, operands of the Newton step
`define FP_POINT5 32'h3f00_0000
`define FP_ONEPOINT5 32'h3fc0_0000

`endif
